// ==== src/xdom_pkg.sv ====
// Shared constants and encodings for the digitizer control block.
// Register addresses are word addresses on the internal 16-bit register bus.
// Modules refer to these by scoped names.
package xdom_pkg;

  localparam int DATA_W      = 16;
  localparam int ADDR_W      = 12;
  localparam int AXI_ADDR_W  = 14;
  localparam int SEL_W       = 5;
  localparam int TAP_W       = 10;
  localparam int TRIG_CONF_W = 7;
  localparam int THR_W       = 12;
  localparam int N_PULSER    = 6;

  // Register map
  typedef enum logic [ADDR_W-1:0] {
    ADR_VERSION       = 12'hFFF,
    ADR_TRIG_CONF     = 12'hBFE,
    ADR_TRIG_THR      = 12'hBFD,
    ADR_SW_MASK_HI    = 12'hBFC,
    ADR_SW_MASK_LO    = 12'hBFB,
    ADR_ARM_MASK_HI   = 12'hBFA,
    ADR_ARM_MASK_LO   = 12'hBF9,
    ADR_TRIG_CTRL     = 12'hBF8,
    ADR_ARMED_HI      = 12'hBF6,
    ADR_ARMED_LO      = 12'hBF5,
    ADR_BUF_SEL       = 12'hBEF,
    ADR_BUF_N_WFMS    = 12'hBEE,
    ADR_BUF_WDS_USED  = 12'hBED,
    ADR_IO_SEL        = 12'hBE6,
    ADR_IO_CTRL       = 12'hBE5,
    ADR_TAP_OUT       = 12'hBE4,
    ADR_PULSER_SINGLE = 12'hBCE,
    ADR_FLUSH         = 12'hBBF,
    ADR_PULSER_PER_HI = 12'hBB3,
    ADR_PULSER_PER_LO = 12'hBB2,
    ADR_PULSER_EN     = 12'hBB1
  } reg_addr_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

// ==== src/axil_reg_slave.sv ====
// AXI4-Lite slave front end for the register file.
// Turns each write into a one-cycle strobe and samples read data on the
// read handshake. One outstanding write and one outstanding read at a time.
`timescale 1ns/100ps

module axil_reg_slave (
  input  logic                            clk,
  input  logic                            rst,
  // Write address and data
  input  logic                            i_awvalid,
  output logic                            o_awready,
  input  logic [xdom_pkg::AXI_ADDR_W-1:0] i_awaddr,
  input  logic                            i_wvalid,
  output logic                            o_wready,
  input  logic [31:0]                     i_wdata,
  // Write response
  output logic                            o_bvalid,
  input  logic                            i_bready,
  output logic [1:0]                      o_bresp,
  // Read address and data
  input  logic                            i_arvalid,
  output logic                            o_arready,
  input  logic [xdom_pkg::AXI_ADDR_W-1:0] i_araddr,
  output logic                            o_rvalid,
  input  logic                            i_rready,
  output logic [31:0]                     o_rdata,
  output logic [1:0]                      o_rresp,
  // Register bus
  output logic                            o_wr_en,
  output logic [xdom_pkg::ADDR_W-1:0]     o_wr_addr,
  output logic [xdom_pkg::DATA_W-1:0]     o_wr_data,
  output logic [xdom_pkg::ADDR_W-1:0]     o_rd_addr,
  input  logic [xdom_pkg::DATA_W-1:0]     i_rd_data
);

  typedef enum logic {WR_IDLE, WR_RESP} wr_state_e;
  typedef enum logic {RD_IDLE, RD_RESP} rd_state_e;

  wr_state_e wr_state;
  rd_state_e rd_state;
  logic      rd_hs;

  ////////////////////////////////////////////////////////////
  // Write channel

  // Address and data are taken together, only while no response waits
  assign o_wr_en   = i_awvalid && i_wvalid && (wr_state == WR_IDLE);
  assign o_awready = o_wr_en;
  assign o_wready  = o_wr_en;
  assign o_wr_addr = i_awaddr[xdom_pkg::AXI_ADDR_W-1:2];
  assign o_wr_data = i_wdata[xdom_pkg::DATA_W-1:0];
  assign o_bvalid  = (wr_state == WR_RESP);
  assign o_bresp   = xdom_pkg::RESP_OKAY;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= WR_IDLE;
    end else if (o_wr_en) begin
      wr_state <= WR_RESP;
    end else if (i_bready) begin
      wr_state <= WR_IDLE;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read channel
  assign rd_hs     = i_arvalid && (rd_state == RD_IDLE);
  assign o_arready = rd_hs;
  assign o_rd_addr = i_araddr[xdom_pkg::AXI_ADDR_W-1:2];
  assign o_rvalid  = (rd_state == RD_RESP);
  assign o_rresp   = xdom_pkg::RESP_OKAY;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= RD_IDLE;
    end else if (rd_hs) begin
      rd_state <= RD_RESP;
    end else if (i_rready) begin
      rd_state <= RD_IDLE;
    end
  end

  // Upper half reads as zero
  always_ff @(posedge clk) begin
    if (rd_hs) begin
      o_rdata <= {16'b0, i_rd_data};
    end
  end

endmodule

// ==== src/xdom_regs.sv ====
// Register file of the control block.
// Holds trigger settings, channel masks and pulser settings, generates the
// trigger, arm, IO and pulser one-shots, runs the flush handshake toward the
// hit buffer and drives the combinational read data.
`timescale 1ns/100ps

module xdom_regs #(
  parameter int N_CHANNELS = 24
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             i_wr_en,
  input  logic [xdom_pkg::ADDR_W-1:0]      i_wr_addr,
  input  logic [xdom_pkg::DATA_W-1:0]      i_wr_data,
  input  logic [xdom_pkg::ADDR_W-1:0]      i_rd_addr,
  output logic [xdom_pkg::DATA_W-1:0]      o_rd_data,
  input  logic [xdom_pkg::DATA_W-1:0]      i_vnum,
  input  logic [N_CHANNELS-1:0]            i_wvb_armed,
  input  logic [xdom_pkg::DATA_W-1:0]      i_n_wfms,
  input  logic [xdom_pkg::DATA_W-1:0]      i_wds_used,
  input  logic [xdom_pkg::TAP_W-1:0]       i_tap_out,
  input  logic                             i_hbuf_flush_ack,
  output logic [xdom_pkg::TRIG_CONF_W-1:0] o_trig_conf,
  output logic [xdom_pkg::THR_W-1:0]       o_trig_thr,
  output logic [N_CHANNELS-1:0]            o_trig_run,
  output logic [N_CHANNELS-1:0]            o_wvb_arm,
  output logic [xdom_pkg::SEL_W-1:0]       o_buf_sel,
  output logic [xdom_pkg::SEL_W-1:0]       o_io_sel,
  output logic [6:0]                       o_io_pulse,
  output logic                             o_hbuf_flush_req,
  output logic [31:0]                      o_pulser_period,
  output logic [xdom_pkg::N_PULSER-1:0]    o_pulser_en,
  output logic [xdom_pkg::N_PULSER-1:0]    o_pulser_single
);

  // Channels above 15 live in the HI registers
  localparam int HI_W = N_CHANNELS - 16;

  logic [N_CHANNELS-1:0] sw_mask;
  logic [N_CHANNELS-1:0] arm_mask;

  ////////////////////////////////////////////////////////////
  // Write decode
  always_ff @(posedge clk) begin
    if (rst) begin
      o_trig_conf      <= '0;
      o_trig_thr       <= '0;
      sw_mask          <= '0;
      arm_mask         <= '0;
      o_trig_run       <= '0;
      o_wvb_arm        <= '0;
      o_buf_sel        <= '0;
      o_io_sel         <= '0;
      o_io_pulse       <= '0;
      o_hbuf_flush_req <= 1'b0;
      o_pulser_period  <= '0;
      o_pulser_en      <= '0;
      o_pulser_single  <= '0;
    end else begin
      // One-shots fall back to zero after a single cycle
      o_trig_run      <= '0;
      o_wvb_arm       <= '0;
      o_io_pulse      <= '0;
      o_pulser_single <= '0;
      if (i_hbuf_flush_ack) begin
        o_hbuf_flush_req <= 1'b0;
      end
      if (i_wr_en) begin
        case (i_wr_addr)
          xdom_pkg::ADR_TRIG_CONF:   o_trig_conf <= i_wr_data[xdom_pkg::TRIG_CONF_W-1:0];
          xdom_pkg::ADR_TRIG_THR:    o_trig_thr <= i_wr_data[xdom_pkg::THR_W-1:0];
          xdom_pkg::ADR_SW_MASK_HI:  sw_mask[N_CHANNELS-1:16] <= i_wr_data[HI_W-1:0];
          xdom_pkg::ADR_SW_MASK_LO:  sw_mask[15:0] <= i_wr_data;
          xdom_pkg::ADR_ARM_MASK_HI: arm_mask[N_CHANNELS-1:16] <= i_wr_data[HI_W-1:0];
          xdom_pkg::ADR_ARM_MASK_LO: arm_mask[15:0] <= i_wr_data;
          xdom_pkg::ADR_TRIG_CTRL: begin
            if (i_wr_data[0]) o_trig_run <= sw_mask;
            if (i_wr_data[1]) o_wvb_arm <= arm_mask;
          end
          xdom_pkg::ADR_BUF_SEL: o_buf_sel <= i_wr_data[xdom_pkg::SEL_W-1:0];
          xdom_pkg::ADR_IO_SEL:  o_io_sel <= i_wr_data[xdom_pkg::SEL_W-1:0];
          // inc/ce/bitslip for both lanes, then discr bitslip
          xdom_pkg::ADR_IO_CTRL: o_io_pulse <= {i_wr_data[8], i_wr_data[6:4], i_wr_data[2:0]};
          xdom_pkg::ADR_PULSER_SINGLE: begin
            o_pulser_single <= i_wr_data[xdom_pkg::N_PULSER-1:0];
          end
          xdom_pkg::ADR_FLUSH: begin
            if (i_wr_data[0] && !i_hbuf_flush_ack) o_hbuf_flush_req <= 1'b1;
          end
          xdom_pkg::ADR_PULSER_PER_HI: o_pulser_period[31:16] <= i_wr_data;
          xdom_pkg::ADR_PULSER_PER_LO: o_pulser_period[15:0] <= i_wr_data;
          xdom_pkg::ADR_PULSER_EN:     o_pulser_en <= i_wr_data[xdom_pkg::N_PULSER-1:0];
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read mux with unmapped addresses reading zero
  always_comb begin
    o_rd_data = '0;
    case (i_rd_addr)
      xdom_pkg::ADR_VERSION:       o_rd_data = i_vnum;
      xdom_pkg::ADR_TRIG_CONF:     o_rd_data[xdom_pkg::TRIG_CONF_W-1:0] = o_trig_conf;
      xdom_pkg::ADR_TRIG_THR:      o_rd_data[xdom_pkg::THR_W-1:0] = o_trig_thr;
      xdom_pkg::ADR_SW_MASK_HI:    o_rd_data[HI_W-1:0] = sw_mask[N_CHANNELS-1:16];
      xdom_pkg::ADR_SW_MASK_LO:    o_rd_data = sw_mask[15:0];
      xdom_pkg::ADR_ARM_MASK_HI:   o_rd_data[HI_W-1:0] = arm_mask[N_CHANNELS-1:16];
      xdom_pkg::ADR_ARM_MASK_LO:   o_rd_data = arm_mask[15:0];
      xdom_pkg::ADR_ARMED_HI:      o_rd_data[HI_W-1:0] = i_wvb_armed[N_CHANNELS-1:16];
      xdom_pkg::ADR_ARMED_LO:      o_rd_data = i_wvb_armed[15:0];
      xdom_pkg::ADR_BUF_SEL:       o_rd_data[xdom_pkg::SEL_W-1:0] = o_buf_sel;
      xdom_pkg::ADR_BUF_N_WFMS:    o_rd_data = i_n_wfms;
      xdom_pkg::ADR_BUF_WDS_USED:  o_rd_data = i_wds_used;
      xdom_pkg::ADR_IO_SEL:        o_rd_data[xdom_pkg::SEL_W-1:0] = o_io_sel;
      xdom_pkg::ADR_TAP_OUT:       o_rd_data[xdom_pkg::TAP_W-1:0] = i_tap_out;
      xdom_pkg::ADR_FLUSH:         o_rd_data[0] = o_hbuf_flush_req | i_hbuf_flush_ack;
      xdom_pkg::ADR_PULSER_PER_HI: o_rd_data = o_pulser_period[31:16];
      xdom_pkg::ADR_PULSER_PER_LO: o_rd_data = o_pulser_period[15:0];
      xdom_pkg::ADR_PULSER_EN:     o_rd_data[xdom_pkg::N_PULSER-1:0] = o_pulser_en;
      default: ;
    endcase
  end

endmodule

// ==== src/chan_status_mux.sv ====
// Per-channel status selection for register readback.
// Picks one channel's slice of the wide status buses and registers it,
// which keeps the wide muxes off the read path.
`timescale 1ns/100ps

module chan_status_mux #(
  parameter int N_CHANNELS = 24
) (
  input  logic                                  clk,
  input  logic [xdom_pkg::SEL_W-1:0]            i_buf_sel,
  input  logic [xdom_pkg::SEL_W-1:0]            i_io_sel,
  input  logic [N_CHANNELS*xdom_pkg::DATA_W-1:0] i_wfms_in_buf,
  input  logic [N_CHANNELS*xdom_pkg::DATA_W-1:0] i_buf_wds_used,
  input  logic [N_CHANNELS*xdom_pkg::TAP_W-1:0]  i_adc_delay_tap,
  output logic [xdom_pkg::DATA_W-1:0]           o_n_wfms,
  output logic [xdom_pkg::DATA_W-1:0]           o_wds_used,
  output logic [xdom_pkg::TAP_W-1:0]            o_tap_out
);

  always_ff @(posedge clk) begin
    o_n_wfms   <= '0;
    o_wds_used <= '0;
    o_tap_out  <= '0;
    // Out of range selects read back as zero
    if (i_buf_sel < N_CHANNELS) begin
      o_n_wfms   <= i_wfms_in_buf[i_buf_sel*xdom_pkg::DATA_W +: xdom_pkg::DATA_W];
      o_wds_used <= i_buf_wds_used[i_buf_sel*xdom_pkg::DATA_W +: xdom_pkg::DATA_W];
    end
    if (i_io_sel < N_CHANNELS) begin
      o_tap_out <= i_adc_delay_tap[i_io_sel*xdom_pkg::TAP_W +: xdom_pkg::TAP_W];
    end
  end

endmodule

// ==== src/io_ctrl_demux.sv ====
// Routes the IO control one-shots to the selected channel.
// Each channel has two ADC lanes and one discriminator input; only the
// selected channel sees the pulse, one cycle after it arrives.
`timescale 1ns/100ps

module io_ctrl_demux #(
  parameter int N_CHANNELS = 24
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [xdom_pkg::SEL_W-1:0]    i_io_sel,
  input  logic [6:0]                    i_io_pulse,
  output logic [2*N_CHANNELS-1:0]       o_adc_delay_ce,
  output logic [2*N_CHANNELS-1:0]       o_adc_delay_inc,
  output logic [2*N_CHANNELS-1:0]       o_adc_bitslip,
  output logic [N_CHANNELS-1:0]         o_discr_bitslip
);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_adc_delay_ce  <= '0;
      o_adc_delay_inc <= '0;
      o_adc_bitslip   <= '0;
      o_discr_bitslip <= '0;
    end else begin
      for (int c = 0; c < N_CHANNELS; c++) begin
        // Pulse layout is lane 0 in bits 2:0, lane 1 in bits 5:3
        o_adc_delay_inc[2*c +: 2] <= (i_io_sel == c) ? {i_io_pulse[3], i_io_pulse[0]} : 2'b0;
        o_adc_delay_ce[2*c +: 2]  <= (i_io_sel == c) ? {i_io_pulse[4], i_io_pulse[1]} : 2'b0;
        o_adc_bitslip[2*c +: 2]   <= (i_io_sel == c) ? {i_io_pulse[5], i_io_pulse[2]} : 2'b0;
        o_discr_bitslip[c]        <= (i_io_sel == c) && i_io_pulse[6];
      end
    end
  end

endmodule

// ==== src/periodic_pulser.sv ====
// AFE pulser trigger generation.
// A free-running counter ticks once every i_period cycles; the tick is
// masked per output and merged with the single-shot pulses.
`timescale 1ns/100ps

module periodic_pulser (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [31:0]                   i_period,
  input  logic [xdom_pkg::N_PULSER-1:0] i_enable,
  input  logic [xdom_pkg::N_PULSER-1:0] i_single,
  output logic [xdom_pkg::N_PULSER-1:0] o_pulser_trig
);

  logic [31:0] count;
  logic        tick;

  always_ff @(posedge clk) begin
    if (rst || i_period == 0) begin
      count <= '0;
      tick  <= 1'b0;
    end else if (count >= i_period - 1) begin
      count <= '0;
      tick  <= 1'b1;
    end else begin
      count <= count + 1;
      tick  <= 1'b0;
    end
  end

  assign o_pulser_trig = i_single | ({xdom_pkg::N_PULSER{tick}} & i_enable);

endmodule

// ==== src/xdom.sv ====
// Top level of the digitizer control and status block.
// AXI4-Lite slave in front of the register file, plus the channel status
// muxes, IO control demux and pulser trigger generator.
`timescale 1ns/100ps

module xdom #(
  parameter int N_CHANNELS = 24
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   i_awvalid,
  output logic                                   o_awready,
  input  logic [xdom_pkg::AXI_ADDR_W-1:0]        i_awaddr,
  input  logic                                   i_wvalid,
  output logic                                   o_wready,
  input  logic [31:0]                            i_wdata,
  output logic                                   o_bvalid,
  input  logic                                   i_bready,
  output logic [1:0]                             o_bresp,
  input  logic                                   i_arvalid,
  output logic                                   o_arready,
  input  logic [xdom_pkg::AXI_ADDR_W-1:0]        i_araddr,
  output logic                                   o_rvalid,
  input  logic                                   i_rready,
  output logic [31:0]                            o_rdata,
  output logic [1:0]                             o_rresp,
  input  logic [xdom_pkg::DATA_W-1:0]            i_vnum,
  input  logic [N_CHANNELS-1:0]                  i_wvb_armed,
  input  logic [N_CHANNELS*xdom_pkg::DATA_W-1:0] i_wfms_in_buf,
  input  logic [N_CHANNELS*xdom_pkg::DATA_W-1:0] i_buf_wds_used,
  input  logic [N_CHANNELS*xdom_pkg::TAP_W-1:0]  i_adc_delay_tap,
  input  logic                                   i_hbuf_flush_ack,
  output logic                                   o_hbuf_flush_req,
  output logic [xdom_pkg::TRIG_CONF_W-1:0]       o_trig_conf,
  output logic [xdom_pkg::THR_W-1:0]             o_trig_thr,
  output logic [N_CHANNELS-1:0]                  o_trig_run,
  output logic [N_CHANNELS-1:0]                  o_wvb_arm,
  output logic [2*N_CHANNELS-1:0]                o_adc_delay_ce,
  output logic [2*N_CHANNELS-1:0]                o_adc_delay_inc,
  output logic [2*N_CHANNELS-1:0]                o_adc_bitslip,
  output logic [N_CHANNELS-1:0]                  o_discr_bitslip,
  output logic [xdom_pkg::N_PULSER-1:0]          o_pulser_trig
);

  logic                            wr_en;
  logic [xdom_pkg::ADDR_W-1:0]     wr_addr;
  logic [xdom_pkg::DATA_W-1:0]     wr_data;
  logic [xdom_pkg::ADDR_W-1:0]     rd_addr;
  logic [xdom_pkg::DATA_W-1:0]     rd_data;
  logic [xdom_pkg::SEL_W-1:0]      buf_sel;
  logic [xdom_pkg::SEL_W-1:0]      io_sel;
  logic [6:0]                      io_pulse;
  logic [xdom_pkg::DATA_W-1:0]     n_wfms;
  logic [xdom_pkg::DATA_W-1:0]     wds_used;
  logic [xdom_pkg::TAP_W-1:0]      tap_out;
  logic [31:0]                     pulser_period;
  logic [xdom_pkg::N_PULSER-1:0]   pulser_en;
  logic [xdom_pkg::N_PULSER-1:0]   pulser_single;

  ////////////////////////////////////////////////////////////
  // Bus front end and registers
  axil_reg_slave u_axil (
    .clk, .rst,
    .i_awvalid, .o_awready, .i_awaddr, .i_wvalid, .o_wready, .i_wdata,
    .o_bvalid, .i_bready, .o_bresp,
    .i_arvalid, .o_arready, .i_araddr, .o_rvalid, .i_rready, .o_rdata, .o_rresp,
    .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data),
    .o_rd_addr(rd_addr), .i_rd_data(rd_data)
  );

  xdom_regs #(.N_CHANNELS(N_CHANNELS)) u_regs (
    .clk, .rst,
    .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
    .i_rd_addr(rd_addr), .o_rd_data(rd_data),
    .i_vnum, .i_wvb_armed,
    .i_n_wfms(n_wfms), .i_wds_used(wds_used), .i_tap_out(tap_out),
    .i_hbuf_flush_ack, .o_trig_conf, .o_trig_thr, .o_trig_run, .o_wvb_arm,
    .o_buf_sel(buf_sel), .o_io_sel(io_sel), .o_io_pulse(io_pulse),
    .o_hbuf_flush_req, .o_pulser_period(pulser_period),
    .o_pulser_en(pulser_en), .o_pulser_single(pulser_single)
  );

  ////////////////////////////////////////////////////////////
  // Datapath blocks
  chan_status_mux #(.N_CHANNELS(N_CHANNELS)) u_status (
    .clk, .i_buf_sel(buf_sel), .i_io_sel(io_sel),
    .i_wfms_in_buf, .i_buf_wds_used, .i_adc_delay_tap,
    .o_n_wfms(n_wfms), .o_wds_used(wds_used), .o_tap_out(tap_out)
  );

  io_ctrl_demux #(.N_CHANNELS(N_CHANNELS)) u_io (
    .clk, .rst, .i_io_sel(io_sel), .i_io_pulse(io_pulse),
    .o_adc_delay_ce, .o_adc_delay_inc, .o_adc_bitslip, .o_discr_bitslip
  );

  periodic_pulser u_pulser (
    .clk, .rst, .i_period(pulser_period), .i_enable(pulser_en),
    .i_single(pulser_single), .o_pulser_trig
  );

endmodule

// ==== testbench/tb_xdom.sv ====
// Directed testbench for the digitizer control block.
// Drives the AXI4-Lite port, models the channel status buses and the hit
// buffer flush ack, and checks registers, one-shots, IO pulses and pulser.
`timescale 1ns/100ps

module tb_xdom;

  localparam int N_CHANNELS = 24;
  localparam int TIMEOUT_CYCLES = 4000;
  localparam logic [15:0] VNUM = 16'h5a17;
  localparam logic [15:0] HI_MASK = (1 << (N_CHANNELS - 16)) - 1;

  logic clk;
  logic rst;
  logic i_awvalid, o_awready, i_wvalid, o_wready, o_bvalid, i_bready;
  logic i_arvalid, o_arready, o_rvalid, i_rready;
  logic [xdom_pkg::AXI_ADDR_W-1:0] i_awaddr, i_araddr;
  logic [31:0] i_wdata, o_rdata;
  logic [1:0] o_bresp, o_rresp;
  logic [15:0] i_vnum;
  logic [N_CHANNELS-1:0] i_wvb_armed;
  logic [N_CHANNELS*16-1:0] i_wfms_in_buf, i_buf_wds_used;
  logic [N_CHANNELS*xdom_pkg::TAP_W-1:0] i_adc_delay_tap;
  logic i_hbuf_flush_ack, o_hbuf_flush_req;
  logic [xdom_pkg::TRIG_CONF_W-1:0] o_trig_conf;
  logic [xdom_pkg::THR_W-1:0] o_trig_thr;
  logic [N_CHANNELS-1:0] o_trig_run, o_wvb_arm, o_discr_bitslip;
  logic [2*N_CHANNELS-1:0] o_adc_delay_ce, o_adc_delay_inc, o_adc_bitslip;
  logic [xdom_pkg::N_PULSER-1:0] o_pulser_trig;

  int errors, total_errors, tests_passed, tests_failed, cycles;
  int run_hits, arm_hits, io_hits;
  int pulse_cnt [xdom_pkg::N_PULSER];
  logic [N_CHANNELS-1:0] run_seen, arm_seen, discr_seen;
  logic [2*N_CHANNELS-1:0] ce_seen, inc_seen, slip_seen;
  logic [1:0] ack_dly;

  xdom #(.N_CHANNELS(N_CHANNELS)) i_xdom (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Models and monitors

  // Hit buffer acks three cycles after the request and releases when it falls
  always @(posedge clk) begin
    if (rst || !o_hbuf_flush_req) begin
      i_hbuf_flush_ack <= 1'b0;
      ack_dly <= '0;
    end else if (!i_hbuf_flush_ack) begin
      if (ack_dly == 2'd2) i_hbuf_flush_ack <= 1'b1;
      else ack_dly <= ack_dly + 1;
    end
  end

  // Count one-shot cycles and keep the last nonzero value
  always @(posedge clk) begin
    if (o_trig_run != '0) begin
      run_hits <= run_hits + 1;
      run_seen <= o_trig_run;
    end
    if (o_wvb_arm != '0) begin
      arm_hits <= arm_hits + 1;
      arm_seen <= o_wvb_arm;
    end
    if (|{o_adc_delay_ce, o_adc_delay_inc, o_adc_bitslip, o_discr_bitslip}) begin
      io_hits    <= io_hits + 1;
      ce_seen    <= o_adc_delay_ce;
      inc_seen   <= o_adc_delay_inc;
      slip_seen  <= o_adc_bitslip;
      discr_seen <= o_discr_bitslip;
    end
    for (int b = 0; b < xdom_pkg::N_PULSER; b++) begin
      if (o_pulser_trig[b] === 1'b1) pulse_cnt[b] <= pulse_cnt[b] + 1;
    end
  end

  // Run limit well above the length of all tests
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a handshake never completed", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus tasks
  task automatic axi_write(input logic [11:0] addr, input logic [15:0] data);
    i_awaddr  <= {addr, 2'b00};
    i_wdata   <= {16'ha5a5, data};
    i_awvalid <= 1'b1;
    i_wvalid  <= 1'b1;
    @(posedge clk);
    while (!o_awready) @(posedge clk);
    if (o_wready !== 1'b1) begin
      $display("** Error at %0t: write to %h took the address without the data",
               $time, addr);
      errors++;
    end
    i_awvalid <= 1'b0;
    i_wvalid  <= 1'b0;
    @(posedge clk);
    while (!o_bvalid) @(posedge clk);
    if (o_bresp !== xdom_pkg::RESP_OKAY) begin
      $display("** Error at %0t: write to %h gave response %b", $time, addr, o_bresp);
      errors++;
    end
  endtask

  task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
    i_araddr  <= {addr, 2'b00};
    i_arvalid <= 1'b1;
    @(posedge clk);
    while (!o_arready) @(posedge clk);
    i_arvalid <= 1'b0;
    @(posedge clk);
    while (!o_rvalid) @(posedge clk);
    data = o_rdata;
    if (o_rresp !== xdom_pkg::RESP_OKAY) begin
      $display("** Error at %0t: read of %h gave response %b", $time, addr, o_rresp);
      errors++;
    end
  endtask

  task automatic read_expect(input logic [11:0] addr, input logic [15:0] exp, input string what);
    logic [31:0] got;
    axi_read(addr, got);
    if (got !== {16'h0, exp}) begin
      $display("** Error at %0t: %s read %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    if (errors == 0) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors);
    end
    total_errors += errors;
    errors = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  task automatic check_config_regs();
    logic [15:0] conf, thr, sw_lo, sw_hi, arm_lo, arm_hi, per_lo, per_hi;
    conf = $urandom;
    thr = $urandom;
    sw_lo = $urandom;
    sw_hi = $urandom;
    arm_lo = $urandom;
    arm_hi = $urandom;
    per_lo = $urandom;
    per_hi = $urandom;
    axi_write(xdom_pkg::ADR_TRIG_CONF, conf);
    axi_write(xdom_pkg::ADR_TRIG_THR, thr);
    axi_write(xdom_pkg::ADR_SW_MASK_LO, sw_lo);
    axi_write(xdom_pkg::ADR_SW_MASK_HI, sw_hi);
    axi_write(xdom_pkg::ADR_ARM_MASK_LO, arm_lo);
    axi_write(xdom_pkg::ADR_ARM_MASK_HI, arm_hi);
    axi_write(xdom_pkg::ADR_PULSER_PER_LO, per_lo);
    axi_write(xdom_pkg::ADR_PULSER_PER_HI, per_hi);
    read_expect(xdom_pkg::ADR_TRIG_CONF, conf & 16'h007f, "TRIG_CONF");
    read_expect(xdom_pkg::ADR_TRIG_THR, thr & 16'h0fff, "TRIG_THR");
    read_expect(xdom_pkg::ADR_SW_MASK_LO, sw_lo, "SW_MASK_LO");
    read_expect(xdom_pkg::ADR_SW_MASK_HI, sw_hi & HI_MASK, "SW_MASK_HI");
    read_expect(xdom_pkg::ADR_ARM_MASK_LO, arm_lo, "ARM_MASK_LO");
    read_expect(xdom_pkg::ADR_ARM_MASK_HI, arm_hi & HI_MASK, "ARM_MASK_HI");
    read_expect(xdom_pkg::ADR_PULSER_PER_LO, per_lo, "PULSER_PER_LO");
    read_expect(xdom_pkg::ADR_PULSER_PER_HI, per_hi, "PULSER_PER_HI");
    read_expect(12'h123, 16'h0000, "unmapped address");
    read_expect(xdom_pkg::ADR_VERSION, VNUM, "VERSION");
    if (o_trig_conf !== conf[6:0] || o_trig_thr !== thr[11:0]) begin
      $display("** Error at %0t: trigger outputs %h/%h, expected %h/%h",
               $time, o_trig_conf, o_trig_thr, conf[6:0], thr[11:0]);
      errors++;
    end
  endtask

  task automatic check_status_select();
    int ch;
    for (int n = 0; n < 3; n++) begin
      ch = $urandom % N_CHANNELS;
      axi_write(xdom_pkg::ADR_BUF_SEL, ch);
      axi_write(xdom_pkg::ADR_IO_SEL, ch);
      read_expect(xdom_pkg::ADR_BUF_SEL, ch, "BUF_SEL");
      read_expect(xdom_pkg::ADR_BUF_N_WFMS, ch + 100, "BUF_N_WFMS");
      read_expect(xdom_pkg::ADR_BUF_WDS_USED, ch * 3, "BUF_WDS_USED");
      read_expect(xdom_pkg::ADR_TAP_OUT, (ch + 7) & 16'h03ff, "TAP_OUT");
    end
  endtask

  task automatic check_trigger_oneshots();
    logic [N_CHANNELS-1:0] sw, arm, armed;
    int run0, arm0;
    sw = $urandom | 1;
    arm = $urandom | 1;
    armed = $urandom;
    axi_write(xdom_pkg::ADR_SW_MASK_LO, sw[15:0]);
    axi_write(xdom_pkg::ADR_SW_MASK_HI, sw[N_CHANNELS-1:16]);
    axi_write(xdom_pkg::ADR_ARM_MASK_LO, arm[15:0]);
    axi_write(xdom_pkg::ADR_ARM_MASK_HI, arm[N_CHANNELS-1:16]);
    i_wvb_armed <= armed;
    read_expect(xdom_pkg::ADR_ARMED_LO, armed[15:0], "ARMED_LO");
    read_expect(xdom_pkg::ADR_ARMED_HI, armed[N_CHANNELS-1:16], "ARMED_HI");
    run0 = run_hits;
    arm0 = arm_hits;
    axi_write(xdom_pkg::ADR_TRIG_CTRL, 16'h0003);
    repeat (4) @(posedge clk);
    if (run_hits - run0 != 1 || run_seen !== sw) begin
      $display("** Error at %0t: o_trig_run high %0d cycles with %h, expected 1 with %h",
               $time, run_hits - run0, run_seen, sw);
      errors++;
    end
    if (arm_hits - arm0 != 1 || arm_seen !== arm) begin
      $display("** Error at %0t: o_wvb_arm high %0d cycles with %h, expected 1 with %h",
               $time, arm_hits - arm0, arm_seen, arm);
      errors++;
    end
  endtask

  task automatic check_io_pulses();
    int ch, hits0;
    logic [15:0] d;
    logic [2*N_CHANNELS-1:0] e_inc, e_ce, e_slip;
    logic [N_CHANNELS-1:0] e_discr;
    for (int n = 0; n < 4; n++) begin
      ch = $urandom % N_CHANNELS;
      d = ($urandom & 16'h0177) | 16'h0001;
      axi_write(xdom_pkg::ADR_IO_SEL, ch);
      hits0 = io_hits;
      axi_write(xdom_pkg::ADR_IO_CTRL, d);
      repeat (4) @(posedge clk);
      // Lane 0 is the low bit of each channel pair
      e_inc = '0;
      e_ce = '0;
      e_slip = '0;
      e_discr = '0;
      e_inc[2*ch] = d[0];
      e_inc[2*ch+1] = d[4];
      e_ce[2*ch] = d[1];
      e_ce[2*ch+1] = d[5];
      e_slip[2*ch] = d[2];
      e_slip[2*ch+1] = d[6];
      e_discr[ch] = d[8];
      if (io_hits - hits0 != 1) begin
        $display("** Error at %0t: IO pulses on %0d cycles, expected 1", $time, io_hits - hits0);
        errors++;
      end
      if (inc_seen !== e_inc || ce_seen !== e_ce || slip_seen !== e_slip
          || discr_seen !== e_discr) begin
        $display("** Error at %0t: IO pulse pattern wrong for channel %0d, data %h",
                 $time, ch, d);
        errors++;
      end
    end
  endtask

  task automatic check_flush();
    axi_write(xdom_pkg::ADR_FLUSH, 16'h0001);
    if (o_hbuf_flush_req !== 1'b1) begin
      $display("** Error at %0t: flush request not raised", $time);
      errors++;
    end
    read_expect(xdom_pkg::ADR_FLUSH, 16'h0001, "FLUSH while pending");
    while (!i_hbuf_flush_ack) @(posedge clk);
    while (o_hbuf_flush_req) @(posedge clk);
    while (i_hbuf_flush_ack) @(posedge clk);
    read_expect(xdom_pkg::ADR_FLUSH, 16'h0000, "FLUSH after ack");
  endtask

  task automatic check_pulser();
    int start [xdom_pkg::N_PULSER];
    int n;
    logic [xdom_pkg::N_PULSER-1:0] single;
    axi_write(xdom_pkg::ADR_PULSER_PER_HI, 16'h0000);
    axi_write(xdom_pkg::ADR_PULSER_PER_LO, 16'd10);
    axi_write(xdom_pkg::ADR_PULSER_EN, 16'h0005);
    read_expect(xdom_pkg::ADR_PULSER_EN, 16'h0005, "PULSER_EN");
    repeat (20) @(posedge clk);
    for (int b = 0; b < xdom_pkg::N_PULSER; b++) start[b] = pulse_cnt[b];
    repeat (200) @(posedge clk);
    for (int b = 0; b < xdom_pkg::N_PULSER; b++) begin
      n = pulse_cnt[b] - start[b];
      if ((b == 0 || b == 2) ? (n < 19 || n > 21) : (n != 0)) begin
        $display("** Error at %0t: pulser bit %0d gave %0d pulses in 200 cycles", $time, b, n);
        errors++;
      end
    end
    // Single shots with the periodic source masked off
    axi_write(xdom_pkg::ADR_PULSER_EN, 16'h0000);
    repeat (4) @(posedge clk);
    single = $urandom | 1;
    for (int b = 0; b < xdom_pkg::N_PULSER; b++) start[b] = pulse_cnt[b];
    axi_write(xdom_pkg::ADR_PULSER_SINGLE, single);
    repeat (4) @(posedge clk);
    for (int b = 0; b < xdom_pkg::N_PULSER; b++) begin
      if (pulse_cnt[b] - start[b] != single[b]) begin
        $display("** Error at %0t: single pulse bit %0d high %0d cycles, expected %0d",
                 $time, b, pulse_cnt[b] - start[b], single[b]);
        errors++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  initial begin
    void'($urandom(32'h4b07_215b));
    rst = 1'b1;
    i_awvalid = 1'b0;
    i_wvalid = 1'b0;
    i_arvalid = 1'b0;
    i_awaddr = '0;
    i_araddr = '0;
    i_wdata = '0;
    i_bready = 1'b1;
    i_rready = 1'b1;
    i_vnum = VNUM;
    i_wvb_armed = '0;
    i_hbuf_flush_ack = 1'b0;
    for (int c = 0; c < N_CHANNELS; c++) begin
      i_wfms_in_buf[c*16 +: 16] = c + 100;
      i_buf_wds_used[c*16 +: 16] = c * 3;
      i_adc_delay_tap[c*xdom_pkg::TAP_W +: xdom_pkg::TAP_W] = c + 7;
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);
    check_config_regs();
    report_test("register readback");
    check_status_select();
    report_test("status select");
    check_trigger_oneshots();
    report_test("trigger one-shots");
    check_io_pulses();
    report_test("IO control pulses");
    check_flush();
    report_test("flush handshake");
    check_pulser();
    report_test("pulser triggers");
    $display("Tests passed: %0d, failed: %0d, errors: %0d",
             tests_passed, tests_failed, total_errors);
    if (tests_failed == 0 && total_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== xdom.f ====
src/xdom_pkg.sv
src/axil_reg_slave.sv
src/xdom_regs.sv
src/chan_status_mux.sv
src/io_ctrl_demux.sv
src/periodic_pulser.sv
src/xdom.sv
testbench/tb_xdom.sv

// ==== Bender.yml ====
package:
  name: xdom

sources:
  - src/xdom_pkg.sv
  - src/axil_reg_slave.sv
  - src/xdom_regs.sv
  - src/chan_status_mux.sv
  - src/io_ctrl_demux.sv
  - src/periodic_pulser.sv
  - src/xdom.sv
  - target: test
    files:
      - testbench/tb_xdom.sv
